/* verilog/besm_bus_pkg.sv */
////////////////////////////////////////////////////////////
// Shared definitions of the external bus path
// Bus opcode enumeration, bus I/O register indices,
// default word and address widths, lock bit, step limit
////////////////////////////////////////////////////////////

package besm_bus_pkg;

    // Bus operation codes, as issued by the requester
    typedef enum logic [3:0] {
        IDLE  = 4'd0,    // Nothing to do
        CCRD  = 4'd1,    // Command cache read, no bus activity
        CCWR  = 4'd2,    // Command cache write, no bus activity
        DCRD  = 4'd3,    // Operand cache read, no bus activity
        DCWR  = 4'd4,    // Operand cache write, no bus activity
        FETCH = 4'd8,    // Fetch command word into RG1
        DRD   = 4'd9,    // Read operand into RG2
        DWR   = 4'd10,   // Write RG3 to memory
        RDMWR = 4'd11,   // Atomic read, set lock bit, write back
        BTRWR = 4'd12,   // Block transfer write
        BTRRD = 4'd13,   // Block transfer read
        BICLR = 4'd14,   // Clear bus interrupts, not implemented
        BIRD  = 4'd15    // Read and clear interrupt lines
    } bus_op_e;

    // Bus I/O register selection
    typedef enum logic [1:0] {
        ADDR  = 2'd0,    // RG0 physical address
        CMD   = 2'd1,    // RG1 fetched command
        RDATA = 2'd2,    // RG2 read data
        WDATA = 2'd3     // RG3 write data
    } reg_index_e;

    localparam int WORD_W_DEF = 64;        // Machine word
    localparam int ADDR_W_DEF = 10;        // Word address
    localparam int LOCK_BIT   = 55;        // Semaphore bit of RDMWR

    localparam logic [2:0] MAX_STEP = 3'd7; // Step counter saturates here

endpackage

/* verilog/busio_if.sv */
////////////////////////////////////////////////////////////
// Bus between sequencer, bus I/O registers, memory
// and interrupt latch: strobes, read and write data paths
////////////////////////////////////////////////////////////
`timescale 1ns/1ps

interface busio_if #(
    parameter int word_w = besm_bus_pkg::WORD_W_DEF,
    parameter int addr_w = besm_bus_pkg::ADDR_W_DEF
);
    import besm_bus_pkg::*;

    reg_index_e        arx;        // Register index
    logic              ecx;        // Register port enable
    logic              wrx;        // Register latch enable
    logic              astb;       // Address strobe
    logic              rd;         // Memory read
    logic              wr;         // Memory write
    logic              iack;       // Interrupt acknowledge
    logic [word_w-1:0] bus_rdata;  // Selected read source
    logic [word_w-1:0] mem_rdata;  // Memory read word
    logic [word_w-1:0] irq_rdata;  // Pending interrupts
    logic [word_w-1:0] bus_wdata;  // Word to store
    logic [addr_w-1:0] bus_addr;   // RG0 contents

    modport master (output arx, ecx, wrx, astb, rd, wr, iack);
    modport regs (input arx, ecx, wrx, iack, mem_rdata, irq_rdata,
                  output bus_rdata, bus_wdata, bus_addr);
    modport memory (input astb, rd, wr, arx, bus_addr, bus_wdata, output mem_rdata);
    modport intr (input iack, ecx, wrx, output irq_rdata);

endinterface

/* verilog/bus_sequencer.sv */
////////////////////////////////////////////////////////////
// Bus sequencer, the only master of the external bus
// Step counter, opcode latch, block transfer batch flag
// and per-opcode tables of bus strobes
////////////////////////////////////////////////////////////
`timescale 1ns/1ps

module bus_sequencer (
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 request,  // One-cycle operation start
    input  logic                 suspend,  // Abandon current operation
    input  besm_bus_pkg::bus_op_e req_op,  // Operation to perform
    output logic                 done,     // Operation finished, level
    output logic                 bus_lock, // Atomic RDMWR in progress
    busio_if.master              bus
);
    import besm_bus_pkg::*;

    // One row of a strobe table
    typedef struct packed {
        reg_index_e arx;
        logic       ecx;
        logic       wrx;
        logic       astb;
        logic       rd;
        logic       wr;
        logic       iack;
        logic       done;
    } ctl_t;

    logic [2:0] step;        // Current step of the operation
    bus_op_e    opcode;      // Latched operation
    logic       batch_mode;  // Previous op was a finished block transfer
    ctl_t       ctl;         // Decoded strobes

    // Flags in order ecx, wrx, astb, rd, wr, iack
    function automatic ctl_t step_row(input reg_index_e arx, input logic [5:0] flags);
        ctl_t r;
        r.arx = arx;
        {r.ecx, r.wrx, r.astb, r.rd, r.wr, r.iack} = flags;
        r.done = 1'b0;                              // Table still running
        return r;
    endfunction

    always_ff @(posedge clk) begin
        if (reset) begin
            step <= '0;
        end else if (request) begin
            step <= '0;                             // Restart, aborts any op
        end else if (!done && !suspend && step != MAX_STEP) begin
            step <= step + 3'd1;
        end
    end

    always_ff @(posedge clk) begin
        if (reset || suspend) begin
            opcode <= IDLE;                         // No further strobes
        end else if (request) begin
            opcode <= req_op;
        end
    end

    // Recalculated on every idle cycle after completion
    always_ff @(posedge clk) begin
        if (reset) begin
            batch_mode <= 1'b0;
        end else if (!request && done) begin
            batch_mode <= (opcode == BTRWR || opcode == BTRRD);
        end
    end

    assign bus_lock = (opcode == RDMWR);

    always_comb begin
        ctl = step_row(RDATA, 6'b000000);           // Quiet bus
        ctl.done = 1'b1;
        if (!request && !suspend) begin
            case (opcode)
                FETCH: begin
                    case (step)
                        3'd0: ctl = step_row(ADDR, 6'b101000);   // Send address
                        3'd1: ctl = step_row(CMD, 6'b100100);    // Get data
                        3'd2: ctl = step_row(CMD, 6'b110000);    // Latch into RG1
                        default: ;
                    endcase
                end
                DRD: begin
                    case (step)
                        3'd0: ctl = step_row(ADDR, 6'b101000);
                        3'd1: ctl = step_row(RDATA, 6'b100100);
                        3'd2: ctl = step_row(RDATA, 6'b110000);  // Latch into RG2
                        default: ;
                    endcase
                end
                DWR: begin
                    case (step)
                        3'd0: ctl = step_row(ADDR, 6'b101000);
                        3'd1: ctl = step_row(WDATA, 6'b100000);  // Present RG3
                        3'd2: ctl = step_row(WDATA, 6'b100010);  // Write word
                        default: ;
                    endcase
                end
                RDMWR: begin
                    case (step)
                        3'd0: ctl = step_row(ADDR, 6'b101000);
                        3'd1: ctl = step_row(RDATA, 6'b100100);
                        3'd2: ctl = step_row(RDATA, 6'b110000);  // Old word to RG2
                        3'd3: ctl = step_row(RDATA, 6'b100000);  // RG2 with lock bit
                        3'd4: ctl = step_row(RDATA, 6'b100010);  // Write back
                        default: ;
                    endcase
                end
                BTRWR: begin
                    if (batch_mode) begin
                        case (step)
                            3'd0: ctl = step_row(WDATA, 6'b100000); // Counter already set
                            3'd1: ctl = step_row(WDATA, 6'b100010);
                            default: ;
                        endcase
                    end else begin
                        case (step)
                            3'd0: ctl = step_row(ADDR, 6'b101000);
                            3'd1: ctl = step_row(WDATA, 6'b100000);
                            3'd2: ctl = step_row(WDATA, 6'b100010);
                            default: ;
                        endcase
                    end
                end
                BTRRD: begin
                    if (batch_mode) begin
                        case (step)
                            3'd0: ctl = step_row(RDATA, 6'b100100);
                            3'd1: ctl = step_row(RDATA, 6'b110000);
                            default: ;
                        endcase
                    end else begin
                        case (step)
                            3'd0: ctl = step_row(ADDR, 6'b101000);
                            3'd1: ctl = step_row(RDATA, 6'b100100);
                            3'd2: ctl = step_row(RDATA, 6'b110000);
                            default: ;
                        endcase
                    end
                end
                BIRD: begin
                    case (step)
                        3'd0: ctl = step_row(RDATA, 6'b100001);  // Interrupts on bus
                        3'd1: ctl = step_row(RDATA, 6'b110001);  // Latch and clear
                        default: ;
                    endcase
                end
                default: ;                          // Cache ops, BICLR, unknown
            endcase
        end
    end

    assign bus.arx  = ctl.arx;
    assign bus.ecx  = ctl.ecx;
    assign bus.wrx  = ctl.wrx;
    assign bus.astb = ctl.astb;
    assign bus.rd   = ctl.rd;
    assign bus.wr   = ctl.wr;
    assign bus.iack = ctl.iack;
    assign done     = ctl.done;                     // Also high on request or suspend

endmodule

/* verilog/busio_regs.sv */
////////////////////////////////////////////////////////////
// Bus I/O registers RG0..RG3
// Request loading, read source selection, latching of
// fetched words and write data with RDMWR lock merge
////////////////////////////////////////////////////////////
`timescale 1ns/1ps

module busio_regs #(
    parameter int word_w = besm_bus_pkg::WORD_W_DEF,
    parameter int addr_w = besm_bus_pkg::ADDR_W_DEF
) (
    input  logic              clk,
    input  logic              reset,
    input  logic              request,    // Load RG0 and RG3
    input  logic [addr_w-1:0] req_addr,
    input  logic [word_w-1:0] req_wdata,
    output logic [word_w-1:0] cmd_word,   // RG1
    output logic [word_w-1:0] read_word,  // RG2
    busio_if.regs             bus
);
    import besm_bus_pkg::*;

    logic [addr_w-1:0] rg0;          // Address
    logic [word_w-1:0] rg1;          // Fetched command
    logic [word_w-1:0] rg2;          // Read data
    logic [word_w-1:0] rg3;          // Write data
    logic [word_w-1:0] locked_word;  // RG2 with semaphore bit set
    logic              latch;

    assign latch = bus.ecx && bus.wrx;

    // Interrupt latch answers on acknowledge, memory otherwise
    assign bus.bus_rdata = bus.iack ? bus.irq_rdata : bus.mem_rdata;

    always_ff @(posedge clk) begin
        if (request) begin
            rg0 <= req_addr;
            rg3 <= req_wdata;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            rg1 <= '0;
            rg2 <= '0;
        end else if (latch) begin
            if (bus.arx == CMD) rg1 <= bus.bus_rdata;
            if (bus.arx == RDATA) rg2 <= bus.bus_rdata;
        end
    end

    always_comb begin
        locked_word = rg2;
        locked_word[LOCK_BIT] = 1'b1;  // Mark word as taken
    end

    assign bus.bus_wdata = (bus.arx == WDATA) ? rg3 : locked_word;
    assign bus.bus_addr  = rg0;
    assign cmd_word      = rg1;
    assign read_word     = rg2;

endmodule

/* verilog/memory_controller.sv */
////////////////////////////////////////////////////////////
// External memory target
// Address counter with auto-increment for block transfers
// and a word array with registered read
////////////////////////////////////////////////////////////
`timescale 1ns/1ps

module memory_controller #(
    parameter int word_w = besm_bus_pkg::WORD_W_DEF,
    parameter int addr_w = besm_bus_pkg::ADDR_W_DEF
) (
    input  logic      clk,
    input  logic      reset,
    busio_if.memory   bus
);
    import besm_bus_pkg::*;

    localparam int depth = 1 << addr_w;

    logic [word_w-1:0] mem [0:depth-1];  // Filled by testbench writes
    logic [addr_w-1:0] addr_cnt;         // Next word to access
    logic [addr_w-1:0] wr_addr;
    logic [word_w-1:0] rdata_q;
    logic              writeback;        // RDMWR store of the word just read

    // Write-back goes to the word the read has just passed
    assign writeback = bus.wr && bus.arx == RDATA;
    assign wr_addr   = writeback ? addr_cnt - addr_w'(1) : addr_cnt;

    always_ff @(posedge clk) begin
        if (reset) begin
            addr_cnt <= '0;
        end else if (bus.astb) begin
            addr_cnt <= bus.bus_addr;                // Start of transfer
        end else if (bus.rd || (bus.wr && !writeback)) begin
            addr_cnt <= addr_cnt + addr_w'(1);       // Block transfer advance
        end
    end

    always_ff @(posedge clk) begin
        if (bus.rd) begin
            rdata_q <= mem[addr_cnt];                // Ready one cycle later
        end
        if (bus.wr) begin
            mem[wr_addr] <= bus.bus_wdata;
        end
    end

    assign bus.mem_rdata = rdata_q;

endmodule

/* verilog/interrupt_latch.sv */
////////////////////////////////////////////////////////////
// Interrupt latch, a bus target read by BIRD
// Collects line pulses, clears them once read
////////////////////////////////////////////////////////////
`timescale 1ns/1ps

module interrupt_latch #(
    parameter int word_w = besm_bus_pkg::WORD_W_DEF,
    parameter int irq_w  = 8
) (
    input  logic             clk,
    input  logic             reset,
    input  logic [irq_w-1:0] irq,   // Pulses from devices
    busio_if.intr            bus
);
    logic [irq_w-1:0] pending;
    logic [irq_w-1:0] taken;        // Bits handed to RG2 this cycle
    logic             read_ack;

    assign read_ack = bus.iack && bus.ecx && bus.wrx;
    assign taken    = read_ack ? pending : '0;

    always_ff @(posedge clk) begin
        if (reset) begin
            pending <= '0;
        end else begin
            pending <= (pending & ~taken) | irq;  // New pulse survives the read
        end
    end

    assign bus.irq_rdata = {{(word_w - irq_w){1'b0}}, pending};

endmodule

/* verilog/besm_bus_top.sv */
////////////////////////////////////////////////////////////
// External bus path top level
// Sequencer, bus I/O registers, memory and interrupt latch
////////////////////////////////////////////////////////////
`timescale 1ns/1ps

module besm_bus_top #(
    parameter int word_w = besm_bus_pkg::WORD_W_DEF,
    parameter int addr_w = besm_bus_pkg::ADDR_W_DEF,
    parameter int irq_w  = 8
) (
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 request,
    input  logic                 suspend,
    input  besm_bus_pkg::bus_op_e req_op,
    input  logic [addr_w-1:0]    req_addr,
    input  logic [word_w-1:0]    req_wdata,
    input  logic [irq_w-1:0]     irq,
    output logic                 done,
    output logic                 bus_lock,
    output logic [word_w-1:0]    cmd_word,
    output logic [word_w-1:0]    read_word
);
    busio_if #(.word_w(word_w), .addr_w(addr_w)) bus ();

    bus_sequencer bus_sequencer_inst (
        .clk      (clk),
        .reset    (reset),
        .request  (request),
        .suspend  (suspend),
        .req_op   (req_op),
        .done     (done),
        .bus_lock (bus_lock),
        .bus      (bus.master)
    );

    busio_regs #(.word_w(word_w), .addr_w(addr_w)) busio_regs_inst (
        .clk       (clk),
        .reset     (reset),
        .request   (request),
        .req_addr  (req_addr),
        .req_wdata (req_wdata),
        .cmd_word  (cmd_word),
        .read_word (read_word),
        .bus       (bus.regs)
    );

    memory_controller #(.word_w(word_w), .addr_w(addr_w)) memory_controller_inst (
        .clk   (clk),
        .reset (reset),
        .bus   (bus.memory)
    );

    interrupt_latch #(.word_w(word_w), .irq_w(irq_w)) interrupt_latch_inst (
        .clk   (clk),
        .reset (reset),
        .irq   (irq),
        .bus   (bus.intr)
    );

endmodule

/* verif/besm_bus_asserts.sv */
////////////////////////////////////////////////////////////
// Concurrent assertions on the bus sequencer outputs
// and the bind into bus_sequencer
////////////////////////////////////////////////////////////
`timescale 1ns/1ps

module besm_bus_asserts (
    input logic                  clk,
    input logic                  reset,
    input logic                  request,
    input besm_bus_pkg::bus_op_e req_op,
    input logic                  done,
    input logic                  astb,
    input logic                  rd,
    input logic                  wr,
    input logic                  iack,
    input logic                  ecx,
    input logic                  wrx
);
    import besm_bus_pkg::*;

    int fail_count = 0;                             // Failed assertion count

    one_target: assert property (@(posedge clk) disable iff (reset)
        $onehot0({astb, rd, wr, iack}))
        else begin
            $error("more than one of astb, rd, wr, iack high");
            fail_count++;
        end

    quiet_when_done: assert property (@(posedge clk) disable iff (reset)
        done |-> !(astb || rd || wr || iack || ecx || wrx))
        else begin
            $error("bus strobe high while done is high");
            fail_count++;
        end

    no_write_latch: assert property (@(posedge clk) disable iff (reset) !(wr && wrx))
        else begin
            $error("wr and wrx high together");
            fail_count++;
        end

    done_after_reset: assert property (@(posedge clk) $fell(reset) |-> done)
        else begin
            $error("done low in the first cycle after reset");
            fail_count++;
        end

    // Address, read, latch, then done
    read_latency: assert property (@(posedge clk) disable iff (reset)
        request && (req_op == FETCH || req_op == DRD) |=> !done ##1 !done ##1 !done ##1 done)
        else begin
            $error("done not exactly 4 cycles after FETCH or DRD request");
            fail_count++;
        end

endmodule

bind bus_sequencer besm_bus_asserts besm_bus_asserts_inst (
    .clk     (clk),
    .reset   (reset),
    .request (request),
    .req_op  (req_op),
    .done    (done),
    .astb    (ctl.astb),
    .rd      (ctl.rd),
    .wr      (ctl.wr),
    .iack    (ctl.iack),
    .ecx     (ctl.ecx),
    .wrx     (ctl.wrx)
);

/* verif/tb_besm_bus.sv */
////////////////////////////////////////////////////////////
// Testbench of the external bus path
// Clock, reset, directed bus operations, reference memory
// with block transfer counter, per-test result lines
////////////////////////////////////////////////////////////
`timescale 1ns/1ps

module tb_besm_bus;
    import besm_bus_pkg::*;

    localparam int word_w  = WORD_W_DEF;
    localparam int addr_w  = ADDR_W_DEF;
    localparam int irq_w   = 8;
    localparam int timeout = 20;                    // Cycles allowed until done

    logic              clk;
    logic              reset;
    logic              request;
    logic              suspend;
    bus_op_e           req_op;
    logic [addr_w-1:0] req_addr;
    logic [word_w-1:0] req_wdata;
    logic [irq_w-1:0]  irq;
    logic              done;
    logic              bus_lock;
    logic [word_w-1:0] cmd_word;
    logic [word_w-1:0] read_word;

    logic [word_w-1:0] model_mem [logic [addr_w-1:0]];  // Words written so far
    logic [addr_w-1:0] batch_addr;                  // Model of the memory address counter
    logic              last_block;                  // Previous op was a block transfer
    logic [irq_w-1:0]  irq_pending;                 // Model of the interrupt latch
    logic [word_w-1:0] words [4];
    logic [word_w-1:0] saved_cmd;
    logic [word_w-1:0] saved_read;
    int                i;
    int                test_errors;
    int                errors;
    int                checks;
    int                bound_errors;

    besm_bus_top besm_bus_top_inst (
        .clk       (clk),
        .reset     (reset),
        .request   (request),
        .suspend   (suspend),
        .req_op    (req_op),
        .req_addr  (req_addr),
        .req_wdata (req_wdata),
        .irq       (irq),
        .done      (done),
        .bus_lock  (bus_lock),
        .cmd_word  (cmd_word),
        .read_word (read_word)
    );

    always #4 clk = ~clk;                           // 8 ns period

    task automatic check_word(input string name, input logic [word_w-1:0] actual,
                              input logic [word_w-1:0] expected);
        checks++;
        assert (actual === expected) else begin
            $display("FAILED at %0t ns: %s expected %h, actual %h", $time, name, expected, actual);
            test_errors++;
        end
    endtask

    // Request pulse driven 1 ns after the edge, outputs sampled 1 ns later
    task automatic start_op(input bus_op_e op, input logic [addr_w-1:0] addr,
                            input logic [word_w-1:0] wdata);
        @(posedge clk);
        #1;
        request   = 1'b1;
        req_op    = op;
        req_addr  = addr;
        req_wdata = wdata;
        @(posedge clk);
        #1;
        request = 1'b0;
        #1;
    endtask

    task automatic wait_done(input string what);
        int n;
        n = 0;
        while (!done && n < timeout) begin
            @(posedge clk);
            #2;
            n++;
        end
        if (!done) begin
            $display("Timeout: %s did not finish within %0d cycles", what, timeout);
            test_errors++;
        end
    endtask

    task automatic run_op(input bus_op_e op, input logic [addr_w-1:0] addr,
                          input logic [word_w-1:0] wdata);
        start_op(op, addr, wdata);
        wait_done(op.name());
        last_block = (op == BTRWR || op == BTRRD);
    endtask

    task automatic block_write(input logic [addr_w-1:0] addr, input logic [word_w-1:0] w);
        if (!last_block) batch_addr = addr;        // Address step only outside a batch
        model_mem[batch_addr] = w;
        batch_addr++;
        run_op(BTRWR, addr, w);
    endtask

    task automatic block_read(input logic [addr_w-1:0] addr);
        if (!last_block) batch_addr = addr;
        run_op(BTRRD, addr, '0);
        check_word("read_word", read_word, model_mem[batch_addr]);
        batch_addr++;
    endtask

    task automatic end_test(input int num, input string name);
        $display("test %0d %s: %0d errors", num, name, test_errors);
        errors += test_errors;
        test_errors = 0;
    endtask

    initial begin
        clk = 1'b0;
        reset = 1'b1;
        request = 1'b0;
        suspend = 1'b0;
        req_op = IDLE;
        req_addr = '0;
        req_wdata = '0;
        irq = '0;
        irq_pending = '0;
        last_block = 1'b0;
        batch_addr = '0;
        test_errors = 0;
        errors = 0;
        checks = 0;
        void'($urandom(20));
        repeat (8) @(posedge clk);
        #1;
        reset = 1'b0;

        words[0] = {$urandom, $urandom};            // Single word write, read, fetch
        run_op(DWR, 10'h05a, words[0]);
        model_mem[10'h05a] = words[0];
        run_op(DRD, 10'h05a, '0);
        check_word("read_word", read_word, model_mem[10'h05a]);
        run_op(FETCH, 10'h05a, '0);
        check_word("cmd_word", cmd_word, model_mem[10'h05a]);
        end_test(1, "write read fetch");

        words[1] = {$urandom, $urandom};            // New stored word, RG2 keeps the old one
        run_op(DWR, 10'h05a, words[1]);
        model_mem[10'h05a] = words[1];
        start_op(RDMWR, 10'h05a, '0);
        check_word("bus_lock", word_w'(bus_lock), word_w'(1));
        wait_done("RDMWR");
        last_block = 1'b0;
        check_word("read_word", read_word, words[1]);
        model_mem[10'h05a] = words[1] | (word_w'(1) << LOCK_BIT);
        run_op(DRD, 10'h05a, '0);
        check_word("read_word", read_word, model_mem[10'h05a]);
        end_test(2, "read modify write");

        for (i = 0; i < 4; i++) begin
            words[i] = {$urandom, $urandom};
            block_write(10'h100, words[i]);         // Address ignored inside the batch
        end
        run_op(DRD, 10'h103, '0);                   // Ends the batch
        check_word("read_word", read_word, model_mem[10'h103]);
        for (i = 0; i < 4; i++) begin
            block_read(10'h100);
        end
        end_test(3, "block transfer");

        @(posedge clk);
        #1;
        irq = 8'h02;                                // Line 1
        irq_pending |= irq;
        @(posedge clk);
        #1;
        irq = 8'h20;                                // Line 5
        irq_pending |= irq;
        @(posedge clk);
        #1;
        irq = '0;
        run_op(BIRD, '0, '0);
        check_word("read_word", read_word, word_w'(irq_pending));
        irq_pending = '0;                           // Cleared by the read
        run_op(BIRD, '0, '0);
        check_word("read_word", read_word, word_w'(irq_pending));
        end_test(4, "interrupt read");

        words[0] = {$urandom, $urandom};
        run_op(DWR, 10'h2c3, words[0]);
        model_mem[10'h2c3] = words[0];
        start_op(DWR, 10'h2c3, ~words[0]);          // Returns in step 0
        @(posedge clk);
        #1;
        suspend = 1'b1;                             // Step 1
        #1;
        check_word("done", word_w'(done), word_w'(1));
        @(posedge clk);
        #1;
        suspend = 1'b0;
        #1;
        wait_done("suspended DWR");
        last_block = 1'b0;
        run_op(DRD, 10'h2c3, '0);
        check_word("read_word", read_word, model_mem[10'h2c3]);
        end_test(5, "suspend");

        saved_cmd = cmd_word;
        saved_read = read_word;
        run_op(CCRD, 10'h05a, {$urandom, $urandom});
        run_op(BICLR, 10'h05a, {$urandom, $urandom});
        run_op(bus_op_e'(4'd6), 10'h05a, {$urandom, $urandom});
        check_word("cmd_word", cmd_word, saved_cmd);
        check_word("read_word", read_word, saved_read);
        run_op(DRD, 10'h05a, '0);                   // Memory untouched
        check_word("read_word", read_word, model_mem[10'h05a]);
        end_test(6, "unsupported ops");

        bound_errors = besm_bus_top_inst.bus_sequencer_inst.besm_bus_asserts_inst.fail_count;
        $display("checks: %0d, check errors: %0d, assertion errors: %0d",
                 checks, errors, bound_errors);
        if (errors == 0 && bound_errors == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

/* build.f */
verilog/besm_bus_pkg.sv
verilog/busio_if.sv
verilog/bus_sequencer.sv
verilog/busio_regs.sv
verilog/memory_controller.sv
verilog/interrupt_latch.sv
verilog/besm_bus_top.sv
verif/besm_bus_asserts.sv
verif/tb_besm_bus.sv

/* run_sim.sh */
#!/bin/sh
# Compile and run the bus path testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/1ps --top-module tb_besm_bus \
    -f build.f -o sim_besm_bus

status=0
./obj_dir/sim_besm_bus +verilator+error+limit+100 > sim.log 2>&1 || status=$?
cat sim.log

if grep -q "Test failed" sim.log; then
    exit 1
fi
if [ "$status" -ne 0 ] || ! grep -q "Test completed successfully" sim.log; then
    exit 1
fi
